//--- project.f
+incdir+.
ahb_matrix_pkg.sv
ahb_address_decoder.sv
ahb_ram_slave.sv
ahb_gpio_slave.sv
ahb_response_mux.sv
ahb_lite_matrix.sv
tb_ahb_lite_matrix.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ahb_lite_matrix
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Builds and runs; fails unless the pass message is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_ahb_lite_matrix.sv
`timescale 1ns/1ps
`include "ahb_matrix_config.svh"

module tb_ahb_lite_matrix;

    localparam int RESET_CYCLES = 16;
    localparam int N_WORDS      = 24;
    localparam int N_OFFS       = 8;
    localparam int N_IO         = 16;
    localparam int TOTAL_XFERS  = 4 + 2*N_WORDS + N_WORDS/4 + 18 + 4*N_OFFS + 6 + 3*N_IO + 12;
    localparam longint WATCHDOG_NS = longint'(TOTAL_XFERS) * 40 + RESET_CYCLES * 20;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        ahb_matrix_pkg::hsize_t size;
        ahb_matrix_pkg::haddr_t addr;
        ahb_matrix_pkg::hdata_t data;
    } xfer_t;

    logic                    hclk;
    logic                    arst_n;
    ahb_matrix_pkg::haddr_t  haddr;
    ahb_matrix_pkg::htrans_e htrans;
    ahb_matrix_pkg::hsize_t  hsize;
    logic                    hwrite;
    ahb_matrix_pkg::hdata_t  hwdata;
    ahb_matrix_pkg::hdata_t  hrdata;
    logic                    hready;
    logic                    hresp;
    logic [`N_SWITCHES-1:0]   switches;
    logic [`N_BUTTONS-1:0]    buttons;
    logic [`N_RED_LEDS-1:0]   red_leds;
    logic [`N_GREEN_LEDS-1:0] green_leds;
    logic [`HEX_WIDTH-1:0]    hex;

    // Model state
    ahb_matrix_pkg::hdata_t   ram_model [4096];
    ahb_matrix_pkg::hdata_t   reset_ram_model [1024];
    logic [`N_RED_LEDS-1:0]   red_model;
    logic [`N_GREEN_LEDS-1:0] green_model;
    logic [`HEX_WIDTH-1:0]    hex_model;

    xfer_t                  ap_xfer;   // in address phase
    xfer_t                  dp_xfer;   // in data phase
    ahb_matrix_pkg::haddr_t word_addr [N_WORDS];
    int seed;
    int checks;
    int errors;
    int checks_at_start;
    int errors_at_start;

    ahb_lite_matrix u_ahb_lite_matrix (
        .HCLK          (hclk),
        .arst_n        (arst_n),
        .HADDR         (haddr),
        .HTRANS        (htrans),
        .HSIZE         (hsize),
        .HWRITE        (hwrite),
        .HWDATA        (hwdata),
        .HRDATA        (hrdata),
        .HREADY        (hready),
        .HRESP         (hresp),
        .io_switches   (switches),
        .io_buttons    (buttons),
        .io_red_leds   (red_leds),
        .io_green_leds (green_leds),
        .io_hex        (hex)
    );

    initial begin
        hclk = 1'b0;
        forever #10 hclk = ~hclk;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    function automatic ahb_matrix_pkg::hdata_t expected_read(input ahb_matrix_pkg::haddr_t addr);
        if (addr[28:22] == `RESET_RAM_ADDR_MATCH) begin
            return reset_ram_model[addr[11:2]];
        end
        if (addr[28:22] == `GPIO_ADDR_MATCH) begin
            case (addr[21:2])
                20'd0:   return ahb_matrix_pkg::hdata_t'(red_model);
                20'd1:   return ahb_matrix_pkg::hdata_t'(green_model);
                20'd2:   return ahb_matrix_pkg::hdata_t'(hex_model);
                20'd3:   return ahb_matrix_pkg::hdata_t'(switches);
                20'd4:   return ahb_matrix_pkg::hdata_t'(buttons);
                default: return '0;
            endcase
        end
        return ram_model[addr[13:2]];
    endfunction

    // A transfer of 2**size bytes covers the lanes of its size-aligned block
    task automatic model_write(input xfer_t x);
        ahb_matrix_pkg::hdata_t word;
        int nbytes;
        int first;
        nbytes = 1 << x.size;
        first  = int'(x.addr[1:0]) & ~(nbytes - 1);
        if (x.addr[28:22] == `GPIO_ADDR_MATCH) begin
            case (x.addr[21:2])
                20'd0:   red_model   = x.data[`N_RED_LEDS-1:0];
                20'd1:   green_model = x.data[`N_GREEN_LEDS-1:0];
                20'd2:   hex_model   = x.data[`HEX_WIDTH-1:0];
                default: ;
            endcase
        end else begin
            word = expected_read(x.addr);
            for (int b = first; b < first + nbytes; b++) begin
                word[8*b +: 8] = x.data[8*b +: 8];
            end
            if (x.addr[28:22] == `RESET_RAM_ADDR_MATCH) reset_ram_model[x.addr[11:2]] = word;
            else ram_model[x.addr[13:2]] = word;
        end
    endtask

    task automatic check_value(input string name, input ahb_matrix_pkg::hdata_t got,
                               input ahb_matrix_pkg::hdata_t exp);
        checks++;
        assert (got === exp) else begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    task automatic issue(input logic valid, input logic write, input ahb_matrix_pkg::hsize_t size,
                         input ahb_matrix_pkg::haddr_t addr, input ahb_matrix_pkg::hdata_t data);
        @(posedge hclk);
        #2;
        dp_xfer = ap_xfer;
        hwdata  = ap_xfer.write ? ap_xfer.data : ahb_matrix_pkg::hdata_t'($random(seed));
        ap_xfer = '{valid: valid, write: write, size: size, addr: addr, data: data};
        haddr   = addr;
        htrans  = valid ? ahb_matrix_pkg::NONSEQ : ahb_matrix_pkg::IDLE;
        hsize   = size;
        hwrite  = write;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) issue(1'b0, 1'b0, 3'b010, '0, '0);
    endtask

    task automatic finish_test(input string name);
        idle_cycles(2);            // drain both pipeline stages
        @(negedge hclk);
        #1;
        $display("test %-16s %0d checks, %0d errors", name,
                 checks - checks_at_start, errors - errors_at_start);
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    // Checks the outputs every cycle and the transfer in its data phase
    initial begin : compare
        wait (arst_n === 1'b1);
        forever begin
            @(negedge hclk);
            check_value("HREADY", ahb_matrix_pkg::hdata_t'(hready), 32'd1);
            check_value("HRESP", ahb_matrix_pkg::hdata_t'(hresp), 32'd0);
            check_value("io_red_leds", ahb_matrix_pkg::hdata_t'(red_leds),
                        ahb_matrix_pkg::hdata_t'(red_model));
            check_value("io_green_leds", ahb_matrix_pkg::hdata_t'(green_leds),
                        ahb_matrix_pkg::hdata_t'(green_model));
            check_value("io_hex", ahb_matrix_pkg::hdata_t'(hex),
                        ahb_matrix_pkg::hdata_t'(hex_model));
            if (dp_xfer.valid && dp_xfer.write) begin
                model_write(dp_xfer);
            end else if (dp_xfer.valid) begin
                check_value("HRDATA", hrdata, expected_read(dp_xfer.addr));
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------

    initial begin : main
        int j;
        ahb_matrix_pkg::haddr_t tmp;
        ahb_matrix_pkg::haddr_t addr;
        seed = 11;
        checks = 0;
        errors = 0;
        checks_at_start = 0;
        errors_at_start = 0;
        arst_n = 1'b0;
        haddr = '0;
        htrans = ahb_matrix_pkg::IDLE;
        hsize = 3'b010;
        hwrite = 1'b0;
        hwdata = '0;
        switches = '0;
        buttons = '0;
        ap_xfer = '0;
        dp_xfer = '0;
        red_model = '0;
        green_model = '0;
        hex_model = '0;
        repeat (RESET_CYCLES) @(posedge hclk);
        #2 arst_n = 1'b1;

        idle_cycles(4);
        finish_test("reset state");

        for (int i = 0; i < N_WORDS; i++) begin
            word_addr[i] = {18'd0, 12'($random(seed)), 2'b00};
            issue(1'b1, 1'b1, 3'b010, word_addr[i], $random(seed));
            if (i % 4 == 3) issue(1'b1, 1'b0, 3'b010, word_addr[i], '0);   // read after write
        end
        for (int i = N_WORDS - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmp = word_addr[i];
            word_addr[i] = word_addr[j];
            word_addr[j] = tmp;
        end
        for (int i = 0; i < N_WORDS; i++) issue(1'b1, 1'b0, 3'b010, word_addr[i], '0);
        finish_test("ram words");

        for (int lane = 0; lane < 4; lane++) begin
            addr = 32'h0000_8000 + 32'(lane * 16);
            issue(1'b1, 1'b1, 3'b010, addr, $random(seed));
            issue(1'b1, 1'b1, 3'b000, addr + 32'(lane), $random(seed));
            issue(1'b1, 1'b0, 3'b010, addr, '0);
        end
        for (int half = 0; half < 2; half++) begin
            addr = 32'h0000_8100 + 32'(half * 16);
            issue(1'b1, 1'b1, 3'b010, addr, $random(seed));
            issue(1'b1, 1'b1, 3'b001, addr + 32'(half * 2), $random(seed));
            issue(1'b1, 1'b0, 3'b010, addr, '0);
        end
        finish_test("byte lanes");

        for (int i = 0; i < N_OFFS; i++) begin
            addr = {20'd0, 10'($random(seed)), 2'b00};
            issue(1'b1, 1'b1, 3'b010, 32'h1fc0_0000 | addr, $random(seed));
            issue(1'b1, 1'b1, 3'b010, addr, $random(seed));
            issue(1'b1, 1'b0, 3'b010, 32'h1fc0_0000 | addr, '0);
            issue(1'b1, 1'b0, 3'b010, addr, '0);
        end
        finish_test("reset ram");

        for (int r = 0; r < 3; r++) begin
            issue(1'b1, 1'b1, 3'b010, 32'h1f80_0000 + 32'(4 * r), $random(seed));
        end
        for (int r = 0; r < 3; r++) begin
            issue(1'b1, 1'b0, 3'b010, 32'h1f80_0000 + 32'(4 * r), '0);
        end
        finish_test("gpio outputs");

        for (int i = 0; i < N_IO; i++) begin
            issue(1'b1, 1'b0, 3'b010, 32'h1f80_000c, '0);
            // Held through both GPIO data phases
            switches = `N_SWITCHES'($random(seed));
            buttons  = `N_BUTTONS'($random(seed));
            issue(1'b1, 1'b0, 3'b010, 32'h1f80_0010, '0);
            issue(1'b1, 1'b0, 3'b010, word_addr[i % N_WORDS], '0);
        end
        finish_test("gpio inputs");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- ahb_lite_matrix.sv
`timescale 1ns/1ps
`include "ahb_matrix_config.svh"

module ahb_lite_matrix (
    input  logic                       HCLK,
    input  logic                       arst_n,
    input  ahb_matrix_pkg::haddr_t     HADDR,
    input  ahb_matrix_pkg::htrans_e    HTRANS,
    input  ahb_matrix_pkg::hsize_t     HSIZE,
    input  logic                       HWRITE,
    input  ahb_matrix_pkg::hdata_t     HWDATA,
    output ahb_matrix_pkg::hdata_t     HRDATA,
    output logic                       HREADY,
    output logic                       HRESP,
    input  logic [`N_SWITCHES-1:0]     io_switches,
    input  logic [`N_BUTTONS-1:0]      io_buttons,
    output logic [`N_RED_LEDS-1:0]     io_red_leds,
    output logic [`N_GREEN_LEDS-1:0]   io_green_leds,
    output logic [`HEX_WIDTH-1:0]      io_hex
);

    ahb_matrix_pkg::ahb_req_t   req;
    ahb_matrix_pkg::slave_sel_t sel;        // address phase
    ahb_matrix_pkg::slave_sel_t sel_r;      // data phase
    ahb_matrix_pkg::ahb_rsp_t   rsp_reset_ram;
    ahb_matrix_pkg::ahb_rsp_t   rsp_ram;
    ahb_matrix_pkg::ahb_rsp_t   rsp_gpio;

    assign req = '{haddr: HADDR, htrans: HTRANS, hsize: HSIZE, hwrite: HWRITE};

    ahb_address_decoder u_decoder (
        .HCLK   (HCLK),
        .arst_n (arst_n),
        .haddr  (HADDR),
        .hready (HREADY),
        .sel    (sel),
        .sel_r  (sel_r)
    );

    // --------------------------------------------------
    // Slaves
    // --------------------------------------------------

    ahb_ram_slave #(.ADDR_WIDTH(`RESET_RAM_ADDR_WIDTH)) u_reset_ram (
        .HCLK   (HCLK),
        .arst_n (arst_n),
        .req    (req),
        .hsel   (sel[0]),
        .hready (HREADY),
        .hwdata (HWDATA),
        .rsp    (rsp_reset_ram)
    );

    ahb_ram_slave #(.ADDR_WIDTH(`RAM_ADDR_WIDTH)) u_ram (
        .HCLK   (HCLK),
        .arst_n (arst_n),
        .req    (req),
        .hsel   (sel[1]),
        .hready (HREADY),
        .hwdata (HWDATA),
        .rsp    (rsp_ram)
    );

    ahb_gpio_slave u_gpio (
        .HCLK          (HCLK),
        .arst_n        (arst_n),
        .req           (req),
        .hsel          (sel[2]),
        .hready        (HREADY),
        .hwdata        (HWDATA),
        .rsp           (rsp_gpio),
        .io_switches   (io_switches),
        .io_buttons    (io_buttons),
        .io_red_leds   (io_red_leds),
        .io_green_leds (io_green_leds),
        .io_hex        (io_hex)
    );

    ahb_response_mux u_response_mux (
        .sel_r         (sel_r),
        .rsp_reset_ram (rsp_reset_ram),
        .rsp_ram       (rsp_ram),
        .rsp_gpio      (rsp_gpio),
        .HRDATA        (HRDATA),
        .HRESP         (HRESP),
        .HREADY        (HREADY)
    );

endmodule

//--- ahb_response_mux.sv
`timescale 1ns/1ps

module ahb_response_mux (
    input  ahb_matrix_pkg::slave_sel_t sel_r,
    input  ahb_matrix_pkg::ahb_rsp_t   rsp_reset_ram,
    input  ahb_matrix_pkg::ahb_rsp_t   rsp_ram,
    input  ahb_matrix_pkg::ahb_rsp_t   rsp_gpio,
    output ahb_matrix_pkg::hdata_t     HRDATA,
    output logic                       HRESP,
    output logic                       HREADY
);

    ahb_matrix_pkg::ahb_rsp_t rsp;

    // --------------------------------------------------
    // Lowest set bit wins
    // --------------------------------------------------

    always_comb begin
        casez (sel_r)
            3'b??1:  rsp = rsp_reset_ram;
            3'b?10:  rsp = rsp_ram;
            3'b100:  rsp = rsp_gpio;
            default: rsp = rsp_ram;     // nothing selected, as after reset
        endcase
    end

    assign HRDATA = rsp.hrdata;
    assign HRESP  = rsp.hresp;

    // Ready goes back to the decoder and every slave
    assign HREADY = rsp.hreadyout;

endmodule

//--- ahb_gpio_slave.sv
`timescale 1ns/1ps
`include "ahb_matrix_config.svh"

module ahb_gpio_slave (
    input  logic                       HCLK,
    input  logic                       arst_n,
    input  ahb_matrix_pkg::ahb_req_t   req,
    input  logic                       hsel,
    input  logic                       hready,
    input  ahb_matrix_pkg::hdata_t     hwdata,
    output ahb_matrix_pkg::ahb_rsp_t   rsp,
    input  logic [`N_SWITCHES-1:0]     io_switches,
    input  logic [`N_BUTTONS-1:0]      io_buttons,
    output logic [`N_RED_LEDS-1:0]     io_red_leds,
    output logic [`N_GREEN_LEDS-1:0]   io_green_leds,
    output logic [`HEX_WIDTH-1:0]      io_hex
);

    // Word offsets inside the 4 MB window
    localparam logic [19:0] REG_RED_LEDS   = 20'd0;
    localparam logic [19:0] REG_GREEN_LEDS = 20'd1;
    localparam logic [19:0] REG_HEX        = 20'd2;
    localparam logic [19:0] REG_SWITCHES   = 20'd3;
    localparam logic [19:0] REG_BUTTONS    = 20'd4;

    logic                   start;
    logic                   wr_pending;
    logic [19:0]            reg_addr;
    ahb_matrix_pkg::hdata_t rdata;

    assign start = hsel & hready &
                   (req.htrans == ahb_matrix_pkg::NONSEQ || req.htrans == ahb_matrix_pkg::SEQ);

    always_ff @(posedge HCLK) begin
        if (start) begin
            reg_addr <= req.haddr[21:2];
        end
    end

    // --------------------------------------------------
    // Output registers
    // --------------------------------------------------

    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_pending    <= 1'b0;
            io_red_leds   <= '0;
            io_green_leds <= '0;
            io_hex        <= '0;
        end else if (hready) begin
            wr_pending <= start & req.hwrite;
            if (wr_pending) begin
                case (reg_addr)
                    REG_RED_LEDS:   io_red_leds   <= hwdata[`N_RED_LEDS-1:0];
                    REG_GREEN_LEDS: io_green_leds <= hwdata[`N_GREEN_LEDS-1:0];
                    REG_HEX:        io_hex        <= hwdata[`HEX_WIDTH-1:0];
                    default: ;                  // read-only or unmapped
                endcase
            end
        end
    end

    // Readback of the latched offset, zero-extended
    always_comb begin
        case (reg_addr)
            REG_RED_LEDS:   rdata = ahb_matrix_pkg::hdata_t'(io_red_leds);
            REG_GREEN_LEDS: rdata = ahb_matrix_pkg::hdata_t'(io_green_leds);
            REG_HEX:        rdata = ahb_matrix_pkg::hdata_t'(io_hex);
            REG_SWITCHES:   rdata = ahb_matrix_pkg::hdata_t'(io_switches);
            REG_BUTTONS:    rdata = ahb_matrix_pkg::hdata_t'(io_buttons);
            default:        rdata = '0;
        endcase
    end

    assign rsp = '{hrdata: rdata, hreadyout: 1'b1, hresp: 1'b0};

endmodule

//--- ahb_ram_slave.sv
`timescale 1ns/1ps
`include "ahb_matrix_config.svh"

module ahb_ram_slave #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                     HCLK,
    input  logic                     arst_n,
    input  ahb_matrix_pkg::ahb_req_t req,
    input  logic                     hsel,
    input  logic                     hready,
    input  ahb_matrix_pkg::hdata_t   hwdata,
    output ahb_matrix_pkg::ahb_rsp_t rsp
);

    localparam int LANES = `AHB_DATA_WIDTH / 8;

    ahb_matrix_pkg::hdata_t mem [2**ADDR_WIDTH];

    logic                   start;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [LANES-1:0]       lane_mask;
    logic                   wr_pending;
    logic [ADDR_WIDTH-1:0]  wr_addr;
    logic [LANES-1:0]       wr_mask;
    ahb_matrix_pkg::hdata_t fwd_word;
    ahb_matrix_pkg::hdata_t rdata;

    assign start = hsel & hready &
                   (req.htrans == ahb_matrix_pkg::NONSEQ || req.htrans == ahb_matrix_pkg::SEQ);
    assign addr  = req.haddr[ADDR_WIDTH+1:2];

    // Byte lanes touched by the transfer, little-endian
    always_comb begin
        case (req.hsize)
            3'b000:  lane_mask = 4'b0001 << req.haddr[1:0];
            3'b001:  lane_mask = req.haddr[1] ? 4'b1100 : 4'b0011;
            default: lane_mask = 4'b1111;
        endcase
    end

    // --------------------------------------------------
    // Write pipeline
    // --------------------------------------------------

    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_pending <= 1'b0;
        end else if (hready) begin
            wr_pending <= start & req.hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (start & req.hwrite) begin
            wr_addr <= addr;
            wr_mask <= lane_mask;
        end
    end

    // HWDATA is only valid in the data phase
    always_ff @(posedge HCLK) begin
        if (wr_pending & hready) begin
            for (int i = 0; i < LANES; i++) begin
                if (wr_mask[i]) begin
                    mem[wr_addr][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------

    // Bypass a write still in its data phase to the same word
    always_comb begin
        fwd_word = mem[addr];
        if (wr_pending && wr_addr == addr) begin
            for (int i = 0; i < LANES; i++) begin
                if (wr_mask[i]) begin
                    fwd_word[8*i +: 8] = hwdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (start & ~req.hwrite) begin
            rdata <= fwd_word;
        end
    end

    // Zero-wait, never errors
    assign rsp = '{hrdata: rdata, hreadyout: 1'b1, hresp: 1'b0};

endmodule

//--- ahb_address_decoder.sv
`timescale 1ns/1ps
`include "ahb_matrix_config.svh"

module ahb_address_decoder (
    input  logic                       HCLK,
    input  logic                       arst_n,
    input  ahb_matrix_pkg::haddr_t     haddr,
    input  logic                       hready,
    output ahb_matrix_pkg::slave_sel_t sel,
    output ahb_matrix_pkg::slave_sel_t sel_r
);

    // --------------------------------------------------
    // Address phase select
    // --------------------------------------------------

    // Reset RAM, 4 MB window at 0x1fc00000
    assign sel[0] = (haddr[28:22] == `RESET_RAM_ADDR_MATCH);

    // Main RAM, 64 MB window at 0x00000000
    assign sel[1] = (haddr[28:26] == `RAM_ADDR_MATCH);

    // GPIO, 4 MB window at 0x1f800000
    assign sel[2] = (haddr[28:22] == `GPIO_ADDR_MATCH);

    // --------------------------------------------------
    // Data phase select
    // --------------------------------------------------

    // Steers the response mux for the transfer now in its data phase
    always_ff @(posedge HCLK or negedge arst_n) begin
        if (!arst_n) begin
            sel_r <= '0;                // mux falls back to main RAM
        end else if (hready) begin
            sel_r <= sel;
        end
    end

endmodule

//--- ahb_matrix_pkg.sv
`include "ahb_matrix_config.svh"

package ahb_matrix_pkg;

    // --------------------------------------------------
    // Bus vectors
    // --------------------------------------------------

    typedef logic [`AHB_ADDR_WIDTH-1:0]  haddr_t;
    typedef logic [`AHB_DATA_WIDTH-1:0]  hdata_t;
    typedef logic [2:0]                  hsize_t;

    // One bit per slave: 0 reset RAM, 1 main RAM, 2 GPIO
    typedef logic [`AHB_SLAVE_COUNT-1:0] slave_sel_t;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // --------------------------------------------------
    // Address phase, common to all slaves
    // --------------------------------------------------

    typedef struct packed {
        haddr_t  haddr;
        htrans_e htrans;
        hsize_t  hsize;
        logic    hwrite;
    } ahb_req_t;

    // Data phase reply of a single slave
    typedef struct packed {
        hdata_t hrdata;
        logic   hreadyout;
        logic   hresp;      // 0 is OKAY
    } ahb_rsp_t;

endpackage

//--- ahb_matrix_config.svh
`ifndef AHB_MATRIX_CONFIG_SVH
`define AHB_MATRIX_CONFIG_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------

`define AHB_ADDR_WIDTH          32
`define AHB_DATA_WIDTH          32
`define AHB_SLAVE_COUNT         3

// --------------------------------------------------
// Memory sizes, in words
// --------------------------------------------------

`define RESET_RAM_ADDR_WIDTH    10      // 4 KB boot memory
`define RAM_ADDR_WIDTH          12      // 16 KB main memory

// --------------------------------------------------
// Address map
// --------------------------------------------------

// Reset RAM at 0x1fc00000, compared on HADDR[28:22]
`define RESET_RAM_ADDR_MATCH    7'h7f
// GPIO at 0x1f800000, compared on HADDR[28:22]
`define GPIO_ADDR_MATCH         7'h7e
// Main RAM at 0x00000000, compared on HADDR[28:26]
`define RAM_ADDR_MATCH          3'h0

// --------------------------------------------------
// Board I/O widths
// --------------------------------------------------

`define N_SWITCHES              18
`define N_BUTTONS               5
`define N_RED_LEDS              18
`define N_GREEN_LEDS            9
`define HEX_WIDTH               24

`endif
